//--- design/rackctl_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module rackctl_frame_rx (
    input  logic                                    wb_clk_i,
    input  logic                                    rst_i,
    input  logic                                    line_i,
    output logic                                    rx_valid_o,
    output logic [rackctl_link_pkg::FRAME_BITS-1:0] rx_frame_o
);

    logic                                    sync1_q;
    logic                                    sync2_q;
    logic [rackctl_link_pkg::BIT_CNT_W-1:0]  bit_cnt;
    logic [rackctl_link_pkg::FRAME_BITS-1:0] shift_q;
    logic                                    valid_q;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            sync1_q <= line_i;
            sync2_q <= sync1_q;
            valid_q <= 1'b0;
            if (bit_cnt == '0) begin
                // idle, a high sample is the start bit
                if (sync2_q) begin
                    bit_cnt <= rackctl_link_pkg::RX_BIT_COUNT;
                end
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
                if (bit_cnt == rackctl_link_pkg::CNT_LAST) begin
                    valid_q <= 1'b1;
                end
            end
        end
    end

    // data bits arrive MSB first
    always_ff @(posedge wb_clk_i) begin
        if (bit_cnt != '0) begin
            shift_q <= {shift_q[rackctl_link_pkg::FRAME_BITS-2:0], sync2_q};
        end
    end

    assign rx_valid_o = valid_q;
    assign rx_frame_o = shift_q;

endmodule

`default_nettype wire

//--- design/rackctl_frame_tx.sv
`timescale 1ns/1ps
`default_nettype none

module rackctl_frame_tx (
    input  logic                                    wb_clk_i,
    input  logic                                    rst_i,
    input  logic                                    tx_start_i,
    input  logic [rackctl_link_pkg::FRAME_BITS-1:0] tx_frame_i,
    output logic                                    tx_done_o,
    output logic                                    line_o
);

    // start bit sits above the frame
    logic [rackctl_link_pkg::FRAME_BITS:0]  shift_q;
    logic [rackctl_link_pkg::BIT_CNT_W-1:0] bit_cnt;

    // bits still to go on the line, zero when idle
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            bit_cnt <= '0;
        end else if (tx_start_i) begin
            bit_cnt <= rackctl_link_pkg::TX_BIT_COUNT;
        end else if (bit_cnt != '0) begin
            bit_cnt <= bit_cnt - 1'b1;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (tx_start_i) begin
            shift_q <= {1'b1, tx_frame_i};
        end else begin
            shift_q <= {shift_q[rackctl_link_pkg::FRAME_BITS-1:0], 1'b0};
        end
    end

    // line held low whenever nothing is being sent
    assign line_o = (bit_cnt != '0) && shift_q[rackctl_link_pkg::FRAME_BITS];

    // high together with the last data bit
    assign tx_done_o = (bit_cnt == rackctl_link_pkg::CNT_LAST);

endmodule

`default_nettype wire

//--- design/rackctl_link_pkg.sv
`default_nettype none

package rackctl_link_pkg;

    // frame is one start bit, then header and data, MSB first
    localparam int HDR_W = 32;
    localparam int FRAME_BITS = 64;
    localparam int BIT_CNT_W = $clog2(FRAME_BITS + 2);
    localparam logic [BIT_CNT_W-1:0] TX_BIT_COUNT = BIT_CNT_W'(FRAME_BITS + 1);
    localparam logic [BIT_CNT_W-1:0] RX_BIT_COUNT = BIT_CNT_W'(FRAME_BITS);
    localparam logic [BIT_CNT_W-1:0] CNT_LAST = BIT_CNT_W'(1);

    // cycles from tx_done to the response start bit
    localparam int RSP_TIMEOUT = 256;
    // start bit to rx_valid: two sync flops, then the data bits
    localparam int RX_LATENCY = FRAME_BITS + 3;
    localparam int RSP_DEADLINE = RSP_TIMEOUT + RX_LATENCY;
    localparam int TMO_W = $clog2(RSP_DEADLINE);
    localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(RSP_DEADLINE - 1);

    // response status, 2'b00 is never sent and is taken as an error
    localparam logic [1:0] RSP_ACK = 2'd1;
    localparam logic [1:0] RSP_ERR = 2'd2;
    localparam logic [1:0] RSP_RTY = 2'd3;

    // link bridge states
    localparam logic [1:0] BR_IDLE = 2'd0;
    localparam logic [1:0] BR_SEND = 2'd1;
    localparam logic [1:0] BR_WAIT = 2'd2;
    localparam logic [1:0] BR_RESP = 2'd3;

    // same header word, request going out and response coming back
    typedef union packed {
        struct packed {
            logic                                                 we;
            logic [surf_wb_pkg::WB_SEL_W-1:0]                     sel;
            logic [surf_wb_pkg::LINK_ADR_W-1:0]                   adr;
            logic [HDR_W-1-surf_wb_pkg::WB_SEL_W-surf_wb_pkg::LINK_ADR_W-1:0] rsvd;
        } req;
        struct packed {
            logic [1:0]       status;
            logic [HDR_W-3:0] rsvd;
        } rsp;
    } rackctl_hdr_u;

endpackage

`default_nettype wire

//--- design/rackctl_wb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module rackctl_wb_bridge (
    input  logic                                wb_clk_i,
    input  logic                                rst_i,
    input  logic                                cyc_i,
    input  logic                                stb_i,
    input  logic                                we_i,
    input  logic [surf_wb_pkg::LINK_ADR_W-1:0]  adr_i,
    input  logic [surf_wb_pkg::WB_SEL_W-1:0]    sel_i,
    input  logic [surf_wb_pkg::WB_DAT_W-1:0]    dat_i,
    output logic [surf_wb_pkg::WB_DAT_W-1:0]    dat_o,
    output logic                                ack_o,
    output logic                                err_o,
    output logic                                rty_o,
    output logic                                bridge_err_o,
    input  logic                                err_rst_i,
    output logic                                rackctl_tx_o,
    input  logic                                rackctl_rx_i
);

    rackctl_link_pkg::rackctl_hdr_u            req_hdr;
    rackctl_link_pkg::rackctl_hdr_u            rsp_hdr;
    logic [1:0]                                state;
    logic [rackctl_link_pkg::TMO_W-1:0]        tmo_cnt;
    logic                                      tx_start;
    logic                                      tx_done;
    logic                                      rx_valid;
    logic [rackctl_link_pkg::FRAME_BITS-1:0]   tx_frame;
    logic [rackctl_link_pkg::FRAME_BITS-1:0]   rx_frame;
    logic                                      ack_q;
    logic                                      err_q;
    logic                                      rty_q;
    logic                                      berr_q;
    logic [surf_wb_pkg::WB_DAT_W-1:0]          dat_q;

    // request header, host holds these until the response
    always_comb begin
        req_hdr.req.we = we_i;
        req_hdr.req.sel = sel_i;
        req_hdr.req.adr = adr_i;
        req_hdr.req.rsvd = '0;
    end

    assign tx_frame = {req_hdr, we_i ? dat_i : {surf_wb_pkg::WB_DAT_W{1'b0}}};
    assign rsp_hdr = rx_frame[rackctl_link_pkg::FRAME_BITS-1 -: rackctl_link_pkg::HDR_W];

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            state <= rackctl_link_pkg::BR_IDLE;
            tx_start <= 1'b0;
            tmo_cnt <= '0;
            ack_q <= 1'b0;
            err_q <= 1'b0;
            rty_q <= 1'b0;
            berr_q <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (err_rst_i) begin
                berr_q <= 1'b0;
            end
            case (state)
                rackctl_link_pkg::BR_IDLE: begin
                    if (cyc_i && stb_i) begin
                        tx_start <= 1'b1;
                        state <= rackctl_link_pkg::BR_SEND;
                    end
                end
                rackctl_link_pkg::BR_SEND: begin
                    if (tx_done) begin
                        tmo_cnt <= '0;
                        state <= rackctl_link_pkg::BR_WAIT;
                    end
                end
                rackctl_link_pkg::BR_WAIT: begin
                    tmo_cnt <= tmo_cnt + 1'b1;
                    if (rx_valid) begin
                        case (rsp_hdr.rsp.status)
                            rackctl_link_pkg::RSP_ACK: ack_q <= 1'b1;
                            rackctl_link_pkg::RSP_RTY: rty_q <= 1'b1;
                            default: err_q <= 1'b1;
                        endcase
                        state <= rackctl_link_pkg::BR_RESP;
                    end else if (tmo_cnt == rackctl_link_pkg::TMO_LAST) begin
                        // board never answered, flag it until err_rst_i
                        err_q <= 1'b1;
                        berr_q <= 1'b1;
                        state <= rackctl_link_pkg::BR_RESP;
                    end
                end
                default: begin
                    ack_q <= 1'b0;
                    err_q <= 1'b0;
                    rty_q <= 1'b0;
                    state <= rackctl_link_pkg::BR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state == rackctl_link_pkg::BR_WAIT && rx_valid) begin
            dat_q <= rx_frame[surf_wb_pkg::WB_DAT_W-1:0];
        end
    end

    assign dat_o = dat_q;
    assign ack_o = ack_q;
    assign err_o = err_q;
    assign rty_o = rty_q;
    assign bridge_err_o = berr_q;

    rackctl_frame_tx u_tx (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .tx_start_i (tx_start),
        .tx_frame_i (tx_frame),
        .tx_done_o  (tx_done),
        .line_o     (rackctl_tx_o)
    );

    rackctl_frame_rx u_rx (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .line_i     (rackctl_rx_i),
        .rx_valid_o (rx_valid),
        .rx_frame_o (rx_frame)
    );

    // a response is up only in the respond state, and then exactly one strobe
    a_one_rsp: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        (state == rackctl_link_pkg::BR_RESP) ? $onehot({ack_o, err_o, rty_o})
                                             : ({ack_o, err_o, rty_o} == 3'b000));

    a_tx_idle: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        tx_start |-> (u_tx.bit_cnt == '0));

endmodule

`default_nettype wire

//--- design/surf_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module surf_bridge (
    input  logic                                 wb_clk_i,
    input  logic                                 rst_i,
    input  logic                                 cyc_i,
    input  logic                                 stb_i,
    input  logic                                 we_i,
    input  logic [surf_wb_pkg::WB_ADR_W-1:0]     adr_i,
    input  logic [surf_wb_pkg::WB_SEL_W-1:0]     sel_i,
    input  logic [surf_wb_pkg::WB_DAT_W-1:0]     dat_i,
    input  logic [surf_wb_pkg::SEL_W-1:0]        select_i,
    output logic [surf_wb_pkg::WB_DAT_W-1:0]     dat_o,
    output logic                                 ack_o,
    output logic                                 err_o,
    output logic                                 rty_o,
    output logic [surf_wb_pkg::NUM_LINKS-1:0]    bridge_err_o,
    input  logic                                 err_rst_i,
    output logic [surf_wb_pkg::NUM_LINKS-1:0]    rackctl_tx_o,
    input  logic [surf_wb_pkg::NUM_LINKS-1:0]    rackctl_rx_i
);

    logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_cyc;
    logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_stb;
    logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_ack;
    logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_err;
    logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_rty;
    logic [surf_wb_pkg::NUM_LINKS-1:0][surf_wb_pkg::WB_DAT_W-1:0] link_dat;

    wb_link_select u_select (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .cyc_i      (cyc_i),
        .stb_i      (stb_i),
        .select_i   (select_i),
        .dat_o      (dat_o),
        .ack_o      (ack_o),
        .err_o      (err_o),
        .rty_o      (rty_o),
        .link_cyc_o (link_cyc),
        .link_stb_o (link_stb),
        .link_dat_i (link_dat),
        .link_ack_i (link_ack),
        .link_err_i (link_err),
        .link_rty_i (link_rty)
    );

    // address, data, sel and we fan out to every link, only cyc/stb are per link
    for (genvar i = 0; i < surf_wb_pkg::NUM_LINKS; i++) begin : g_link
        rackctl_wb_bridge u_bridge (
            .wb_clk_i     (wb_clk_i),
            .rst_i        (rst_i),
            .cyc_i        (link_cyc[i]),
            .stb_i        (link_stb[i]),
            .we_i         (we_i),
            .adr_i        (adr_i[surf_wb_pkg::LINK_ADR_W-1:0]),
            .sel_i        (sel_i),
            .dat_i        (dat_i),
            .dat_o        (link_dat[i]),
            .ack_o        (link_ack[i]),
            .err_o        (link_err[i]),
            .rty_o        (link_rty[i]),
            .bridge_err_o (bridge_err_o[i]),
            .err_rst_i    (err_rst_i),
            .rackctl_tx_o (rackctl_tx_o[i]),
            .rackctl_rx_i (rackctl_rx_i[i])
        );
    end

endmodule

`default_nettype wire

//--- design/surf_wb_pkg.sv
`default_nettype none

package surf_wb_pkg;

    // host side Wishbone port
    localparam int WB_ADR_W = 25;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = 4;

    // address bits that reach a remote board
    localparam int LINK_ADR_W = 22;

    // select 0 is reserved, selects 1 to NUM_LINKS map to link 0 to NUM_LINKS-1
    localparam int NUM_LINKS = 7;
    localparam int SEL_W = 3;

endpackage

`default_nettype wire

//--- design/wb_link_select.sv
`timescale 1ns/1ps
`default_nettype none

module wb_link_select (
    input  logic                                                       wb_clk_i,
    input  logic                                                       rst_i,
    input  logic                                                       cyc_i,
    input  logic                                                       stb_i,
    input  logic [surf_wb_pkg::SEL_W-1:0]                              select_i,
    output logic [surf_wb_pkg::WB_DAT_W-1:0]                           dat_o,
    output logic                                                       ack_o,
    output logic                                                       err_o,
    output logic                                                       rty_o,
    output logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_cyc_o,
    output logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_stb_o,
    input  logic [surf_wb_pkg::NUM_LINKS-1:0][surf_wb_pkg::WB_DAT_W-1:0] link_dat_i,
    input  logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_ack_i,
    input  logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_err_i,
    input  logic [surf_wb_pkg::NUM_LINKS-1:0]                          link_rty_i
);

    logic [surf_wb_pkg::SEL_W-1:0] sel_q;
    logic [surf_wb_pkg::SEL_W-1:0] link_idx;
    logic                          cs_q;
    logic                          bad_err_q;
    logic                          sel_ok;
    logic                          sel_q_ok;

    assign sel_ok = (select_i != '0) &&
                    (select_i <= surf_wb_pkg::SEL_W'(surf_wb_pkg::NUM_LINKS));

    // one-hot cycle per link, select n goes to link n-1
    always_comb begin
        for (int i = 0; i < surf_wb_pkg::NUM_LINKS; i++) begin
            link_cyc_o[i] = cyc_i && (select_i == surf_wb_pkg::SEL_W'(i + 1));
            link_stb_o[i] = stb_i && (select_i == surf_wb_pkg::SEL_W'(i + 1));
        end
    end

    // bad selects get a single err, on the cycle after the strobe first shows up
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            cs_q <= 1'b0;
            bad_err_q <= 1'b0;
            sel_q <= '0;
        end else begin
            cs_q <= cyc_i && stb_i;
            bad_err_q <= cyc_i && stb_i && !cs_q && !sel_ok;
            if (cyc_i && stb_i) begin
                sel_q <= select_i;
            end
        end
    end

    assign sel_q_ok = (sel_q != '0) &&
                      (sel_q <= surf_wb_pkg::SEL_W'(surf_wb_pkg::NUM_LINKS));
    assign link_idx = sel_q - 1'b1;

    // responses come straight from the link picked by the held select
    assign dat_o = sel_q_ok ? link_dat_i[link_idx] : '0;
    assign ack_o = sel_q_ok && link_ack_i[link_idx];
    assign rty_o = sel_q_ok && link_rty_i[link_idx];
    assign err_o = bad_err_q || (sel_q_ok && link_err_i[link_idx]);

    // one host cycle in flight, so at most one link answers at a time
    a_one_link: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        $onehot0(link_ack_i | link_err_i | link_rty_i));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the surf_bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module surf_bridge_tb -f surf_bridge.f -o surf_bridge_sim \
    && ./obj_dir/surf_bridge_sim > sim.log 2>&1 \
    || { echo "Verilator build or simulation run failed"; exit 1; }

cat sim.log
grep -q "^TEST OK$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- surf_bridge.f
design/surf_wb_pkg.sv
design/rackctl_link_pkg.sv
design/rackctl_frame_tx.sv
design/rackctl_frame_rx.sv
design/rackctl_wb_bridge.sv
design/wb_link_select.sv
design/surf_bridge.sv
tests/surf_link_model.sv
tests/surf_bridge_tb.sv

//--- tests/surf_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module surf_bridge_tb;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TXN = 22;
    localparam logic [31:0] SEED = 32'h7364;
    // host response as {rty, err, ack}
    localparam logic [2:0] RESP_ACK = 3'b001;
    localparam logic [2:0] RESP_ERR = 3'b010;
    localparam logic [2:0] RESP_RTY = 3'b100;

    logic                                 wb_clk_i;
    logic                                 rst_i;
    logic                                 cyc_i;
    logic                                 stb_i;
    logic                                 we_i;
    logic [surf_wb_pkg::WB_ADR_W-1:0]     adr_i;
    logic [surf_wb_pkg::WB_SEL_W-1:0]     sel_i;
    logic [surf_wb_pkg::WB_DAT_W-1:0]     dat_i;
    logic [surf_wb_pkg::SEL_W-1:0]        select_i;
    logic                                 err_rst_i;
    logic [surf_wb_pkg::WB_DAT_W-1:0]     dat_o;
    logic                                 ack_o;
    logic                                 err_o;
    logic                                 rty_o;
    logic [surf_wb_pkg::NUM_LINKS-1:0]    bridge_err_o;
    logic [surf_wb_pkg::NUM_LINKS-1:0]    rackctl_tx_o;
    wire  [surf_wb_pkg::NUM_LINKS-1:0]    rackctl_rx_i;
    logic [surf_wb_pkg::NUM_LINKS-1:0]    silent;
    logic [31:0]                          lfsr_q;
    int                                   errors = 0;
    int                                   tests_run = 0;
    int                                   tests_failed = 0;
    int                                   tx_high_cycles = 0;

    surf_bridge u_dut (.*);

    for (genvar i = 0; i < surf_wb_pkg::NUM_LINKS; i++) begin : g_board
        surf_link_model u_board (
            .wb_clk_i (wb_clk_i),
            .rst_i    (rst_i),
            .silent_i (silent[i]),
            .line_i   (rackctl_tx_o[i]),
            .line_o   (rackctl_rx_i[i])
        );
    end

    always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

    // counts cycles with any link line high
    always @(negedge wb_clk_i) begin
        if (rackctl_tx_o != '0) begin
            tx_high_cycles = tx_high_cycles + 1;
        end
    end

    initial begin
        #(NUM_TXN * 420 * CLK_PERIOD);
        $display("watchdog: the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[b] = lfsr_q[0];
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL %s expected %h actual %h", name, exp, act);
        errors++;
    endtask

    task automatic end_test(input string name, input int start_errs);
        tests_run++;
        if (errors == start_errs) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - start_errs);
        end
    endtask

    // one classic cycle, held until a response strobe shows up
    task automatic access(input string name, input logic [2:0] link_sel, input logic we,
                          input logic [24:0] adr, input logic [3:0] bsel,
                          input logic [31:0] wdat, input logic [2:0] exp_rsp,
                          output logic [31:0] rdat);
        logic [2:0] rsp;
        @(negedge wb_clk_i);
        select_i = link_sel;
        we_i = we;
        adr_i = adr;
        sel_i = bsel;
        dat_i = wdat;
        cyc_i = 1'b1;
        stb_i = 1'b1;
        rsp = 3'b000;
        while (rsp == 3'b000) begin
            @(negedge wb_clk_i);
            rsp = {rty_o, err_o, ack_o};
            rdat = dat_o;
        end
        cyc_i = 1'b0;
        stb_i = 1'b0;
        if (rsp !== exp_rsp) begin
            report_mismatch(name, 32'(exp_rsp), 32'(rsp));
        end
    endtask

    task automatic reset_values();
        int start_errs;
        start_errs = errors;
        if ({ack_o, err_o, rty_o} !== 3'b000) begin
            report_mismatch("reset_values", 32'h0, 32'({ack_o, err_o, rty_o}));
        end
        if ({bridge_err_o, rackctl_tx_o} !== '0) begin
            report_mismatch("reset_values", 32'h0, 32'({bridge_err_o, rackctl_tx_o}));
        end
        end_test("reset_values", start_errs);
    endtask

    task automatic write_read_all();
        logic [31:0] wdat [surf_wb_pkg::NUM_LINKS];
        logic [31:0] rdat;
        int start_errs;
        start_errs = errors;
        // same address everywhere, each board keeps its own word
        for (int i = 0; i < surf_wb_pkg::NUM_LINKS; i++) begin
            rand_word(wdat[i]);
            access("write_read_all", 3'(i + 1), 1'b1, 25'h5, 4'hf, wdat[i], RESP_ACK, rdat);
        end
        for (int i = 0; i < surf_wb_pkg::NUM_LINKS; i++) begin
            access("write_read_all", 3'(i + 1), 1'b0, 25'h5, 4'hf, 32'h0, RESP_ACK, rdat);
            if (rdat !== wdat[i]) begin
                report_mismatch("write_read_all", wdat[i], rdat);
            end
        end
        end_test("write_read_all", start_errs);
    endtask

    task automatic partial_write();
        logic [31:0] old_w;
        logic [31:0] new_w;
        logic [31:0] exp_w;
        logic [31:0] rdat;
        logic [3:0]  bsel;
        int start_errs;
        start_errs = errors;
        rand_word(old_w);
        rand_word(new_w);
        bsel = 4'b0110;
        access("partial_write", 3'd3, 1'b1, 25'h2a, 4'hf, old_w, RESP_ACK, rdat);
        access("partial_write", 3'd3, 1'b1, 25'h2a, bsel, new_w, RESP_ACK, rdat);
        access("partial_write", 3'd3, 1'b0, 25'h2a, 4'hf, 32'h0, RESP_ACK, rdat);
        for (int b = 0; b < 4; b++) begin
            exp_w[8*b +: 8] = bsel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        if (rdat !== exp_w) begin
            report_mismatch("partial_write", exp_w, rdat);
        end
        end_test("partial_write", start_errs);
    endtask

    task automatic invalid_select();
        logic [31:0] rdat;
        int tx_before;
        int start_errs;
        start_errs = errors;
        tx_before = tx_high_cycles;
        access("invalid_select", 3'd0, 1'b0, 25'h5, 4'hf, 32'h0, RESP_ERR, rdat);
        repeat (4) @(negedge wb_clk_i);
        if (tx_high_cycles != tx_before) begin
            $display("invalid_select: a link sent a frame for select 0");
            errors++;
        end
        end_test("invalid_select", start_errs);
    endtask

    task automatic remote_status();
        logic [31:0] rdat;
        int start_errs;
        start_errs = errors;
        access("remote_status", 3'd2, 1'b0, 25'h200007, 4'hf, 32'h0, RESP_ERR, rdat);
        access("remote_status", 3'd2, 1'b1, 25'h100007, 4'hf, 32'h1234, RESP_RTY, rdat);
        if (bridge_err_o !== '0) begin
            report_mismatch("remote_status", 32'h0, 32'(bridge_err_o));
        end
        end_test("remote_status", start_errs);
    endtask

    task automatic silent_link();
        logic [31:0] rdat;
        int start_errs;
        start_errs = errors;
        silent[3] = 1'b1;
        access("silent_link", 3'd4, 1'b0, 25'h3, 4'hf, 32'h0, RESP_ERR, rdat);
        if (bridge_err_o !== 7'b0001000) begin
            report_mismatch("silent_link", 32'h8, 32'(bridge_err_o));
        end
        silent[3] = 1'b0;
        // sticky bit survives a good access
        access("silent_link", 3'd4, 1'b0, 25'h3, 4'hf, 32'h0, RESP_ACK, rdat);
        if (bridge_err_o !== 7'b0001000) begin
            report_mismatch("silent_link", 32'h8, 32'(bridge_err_o));
        end
        @(negedge wb_clk_i);
        err_rst_i = 1'b1;
        @(negedge wb_clk_i);
        err_rst_i = 1'b0;
        @(negedge wb_clk_i);
        if (bridge_err_o !== '0) begin
            report_mismatch("silent_link", 32'h0, 32'(bridge_err_o));
        end
        end_test("silent_link", start_errs);
    endtask

    initial begin
        wb_clk_i = 1'b0;
        rst_i = 1'b1;
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i = 1'b0;
        adr_i = '0;
        sel_i = '0;
        dat_i = '0;
        select_i = '0;
        err_rst_i = 1'b0;
        silent = '0;
        lfsr_q = SEED;
        repeat (3) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        rst_i = 1'b0;
        reset_values();
        write_read_all();
        partial_write();
        invalid_select();
        remote_status();
        silent_link();
        $display("tests %0d, failed tests %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/surf_link_model.sv
`timescale 1ns/1ps
`default_nettype none

module surf_link_model (
    input  logic wb_clk_i,
    input  logic rst_i,
    input  logic silent_i,
    input  logic line_i,
    output logic line_o
);

    localparam int GAP_CYCLES = 10;
    localparam int FB = rackctl_link_pkg::FRAME_BITS;

    logic [surf_wb_pkg::WB_DAT_W-1:0] mem [64];
    logic [FB-1:0]                    req_frame;
    logic [FB-1:0]                    rsp_frame;
    logic [surf_wb_pkg::WB_DAT_W-1:0] rsp_data;
    rackctl_link_pkg::rackctl_hdr_u   req_hdr;
    rackctl_link_pkg::rackctl_hdr_u   rsp_hdr;
    logic [5:0]                       idx;

    // line is sampled and driven on the falling edge, half a cycle from the DUT
    initial begin
        line_o = 1'b0;
        forever begin
            @(negedge wb_clk_i);
            if (rst_i) begin
                for (int w = 0; w < 64; w++) begin
                    mem[w] = '0;
                end
            end else if (line_i) begin
                for (int b = 0; b < FB; b++) begin
                    @(negedge wb_clk_i);
                    req_frame = {req_frame[FB-2:0], line_i};
                end
                req_hdr = req_frame[FB-1 -: rackctl_link_pkg::HDR_W];
                idx = req_hdr.req.adr[5:0];
                rsp_hdr = '0;
                rsp_data = '0;
                if (req_hdr.req.adr[21]) begin
                    rsp_hdr.rsp.status = rackctl_link_pkg::RSP_ERR;
                end else if (req_hdr.req.adr[20]) begin
                    rsp_hdr.rsp.status = rackctl_link_pkg::RSP_RTY;
                end else begin
                    rsp_hdr.rsp.status = rackctl_link_pkg::RSP_ACK;
                    // byte lanes follow sel
                    for (int b = 0; b < 4; b++) begin
                        if (req_hdr.req.we && req_hdr.req.sel[b]) begin
                            mem[idx][8*b +: 8] = req_frame[8*b +: 8];
                        end
                    end
                    rsp_data = mem[idx];
                end
                rsp_frame = {rsp_hdr, rsp_data};
                repeat (GAP_CYCLES) @(negedge wb_clk_i);
                if (!silent_i) begin
                    line_o = 1'b1;
                    for (int b = FB - 1; b >= 0; b--) begin
                        @(negedge wb_clk_i);
                        line_o = rsp_frame[b];
                    end
                    @(negedge wb_clk_i);
                    line_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire
